//--- Makefile
# Verilator flow for the fetch front end

TB_TOP := tb_fetch_top

.PHONY: lint sim clean

# lint the design from its top level
lint:
	verilator --lint-only --timing --top-module fetch_top -f fetch_top.f

# build and run, pass only when the pass line is printed
sim:
	verilator --binary --timing --top-module $(TB_TOP) -Mdir obj_dir -f fetch_top.f
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

//--- fetch_top.f
rtl/fetch_pkg.sv
rtl/icache_if.sv
rtl/if_stage_1.sv
rtl/icache.sv
rtl/if_stage_2.sv
rtl/fetch_top.sv
verif/tb_fetch_top.sv

//--- rtl/fetch_pkg.sv
// fetch package with widths, cache geometry, reset pc, exception causes, stage structs, cache states
package fetch_pkg;

    // datapath widths
    localparam int XLEN = 32;
    localparam int ILEN = 32;

    // direct-mapped cache geometry, one word per line
    localparam int ICACHE_LINES = 16;
    localparam int IDX_W = $clog2(ICACHE_LINES);
    // word offset occupies pc bits 1:0
    localparam int IDX_LSB = 2;
    localparam int TAG_LSB = IDX_LSB + IDX_W;
    localparam int TAG_W = XLEN - TAG_LSB;

    // program counter value after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;

    // address or pc
    typedef logic [XLEN-1:0] xlen_t;
    // one instruction word
    typedef logic [ILEN-1:0] inst_t;
    // line index, pc bits 5:2
    typedef logic [IDX_W-1:0] idx_t;
    // line tag, pc bits 31:6
    typedef logic [TAG_W-1:0] tag_t;

    // risc-v mcause codes for fetch exceptions
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_PAGE_FAULT      = 4'd12
    } exc_cause_t;

    // exception record travelling with a fetched item
    typedef struct packed {
        logic       valid;
        exc_cause_t cause;
        // faulting pc
        xlen_t      origin;
    } exc_t;

    // stage 1 output register
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        exc_t  ex;
    } if1_if2_t;

    // stage 2 output towards the decoder
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
        exc_t  ex;
    } fetch_out_t;

    // cache controller states
    typedef enum logic {
        IC_IDLE,
        IC_REFILL
    } icache_state_t;

endpackage

//--- rtl/fetch_top.sv
// fetch front end top level connecting both fetch stages and the instruction cache
`timescale 1ns/1ps

module fetch_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // memory port
    output logic                  mem_req_o,
    output fetch_pkg::xlen_t      mem_addr_o,
    input  logic                  mem_valid_i,
    input  fetch_pkg::inst_t      mem_data_i,
    input  logic                  mem_fault_i,
    // decode stall level
    input  logic                  stall_i,
    // redirect pulse and target
    input  logic                  redirect_valid_i,
    input  fetch_pkg::xlen_t      redirect_pc_i,
    // fetched item
    output logic                  fetch_valid_o,
    output fetch_pkg::xlen_t      fetch_pc_o,
    output fetch_pkg::inst_t      fetch_inst_o,
    output logic                  fetch_ex_valid_o,
    output fetch_pkg::exc_cause_t fetch_ex_cause_o
);

    icache_if              icache_bus ();

    fetch_pkg::if1_if2_t   if1_if2;
    fetch_pkg::fetch_out_t fetch_out;
    logic                  if2_stall;
    logic                  if1_stall;

    // stage 1 waits for the decoder and for a pending miss
    assign if1_stall = stall_i || if2_stall;

    if_stage_1 i_if_stage_1 (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .stall_i          (if1_stall),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .icache           (icache_bus),
        .fetch_o          (if1_if2)
    );

    icache i_icache (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .icache      (icache_bus),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_valid_i (mem_valid_i),
        .mem_data_i  (mem_data_i),
        .mem_fault_i (mem_fault_i)
    );

    // redirect doubles as the stage 2 flush
    if_stage_2 i_if_stage_2 (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .fetch_i (if1_if2),
        .icache  (icache_bus),
        .stall_i (stall_i),
        .flush_i (redirect_valid_i),
        .fetch_o (fetch_out),
        .stall_o (if2_stall)
    );

    // split the stage 2 item onto the plain outputs
    assign fetch_valid_o    = fetch_out.valid;
    assign fetch_pc_o       = fetch_out.pc;
    assign fetch_inst_o     = fetch_out.inst;
    assign fetch_ex_valid_o = fetch_out.ex.valid;
    assign fetch_ex_cause_o = fetch_out.ex.cause;

endmodule

//--- rtl/icache.sv
// direct-mapped instruction cache with tag, data and fault arrays, refill fsm and kill handling
`timescale 1ns/1ps

module icache (
    input  logic             clk_i,
    input  logic             rstn_i,
    icache_if.cache          icache,
    // external memory port
    output logic             mem_req_o,
    output fetch_pkg::xlen_t mem_addr_o,
    input  logic             mem_valid_i,
    input  fetch_pkg::inst_t mem_data_i,
    input  logic             mem_fault_i
);

    // line storage
    logic [fetch_pkg::ICACHE_LINES-1:0] line_valid_q;
    fetch_pkg::tag_t                    tag_q   [fetch_pkg::ICACHE_LINES];
    fetch_pkg::inst_t                   data_q  [fetch_pkg::ICACHE_LINES];
    logic [fetch_pkg::ICACHE_LINES-1:0] fault_q;

    fetch_pkg::icache_state_t state_q;
    // refill was cancelled, finish it without a response
    logic             killed_q;
    // request that came in while a cancelled refill was still running
    logic             pend_q;
    fetch_pkg::xlen_t pend_addr_q;
    // address of the line being refilled
    fetch_pkg::xlen_t miss_addr_q;
    logic             mem_req_q;

    // response register
    logic             resp_valid_q;
    fetch_pkg::inst_t resp_data_q;
    logic             resp_fault_q;

    // lookup side
    logic             lk_valid;
    fetch_pkg::xlen_t lk_addr;
    fetch_pkg::idx_t  lk_idx;
    fetch_pkg::tag_t  lk_tag;
    logic             hit;

    // refill side
    fetch_pkg::idx_t  miss_idx;
    fetch_pkg::tag_t  miss_tag;
    logic             refill_done;

    // lookups only start in idle, a parked request goes first
    assign lk_valid = (state_q == fetch_pkg::IC_IDLE) && (icache.req_valid || pend_q)
                      && !icache.kill;
    assign lk_addr  = pend_q ? pend_addr_q : icache.req_addr;
    assign lk_idx   = lk_addr[fetch_pkg::TAG_LSB-1:fetch_pkg::IDX_LSB];
    assign lk_tag   = lk_addr[fetch_pkg::XLEN-1:fetch_pkg::TAG_LSB];
    assign hit      = line_valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

    assign miss_idx    = miss_addr_q[fetch_pkg::TAG_LSB-1:fetch_pkg::IDX_LSB];
    assign miss_tag    = miss_addr_q[fetch_pkg::XLEN-1:fetch_pkg::TAG_LSB];
    assign refill_done = (state_q == fetch_pkg::IC_REFILL) && mem_valid_i;

    // word-aligned memory request, one pulse per miss
    assign mem_req_o  = mem_req_q;
    assign mem_addr_o = {miss_addr_q[fetch_pkg::XLEN-1:fetch_pkg::IDX_LSB],
                         {fetch_pkg::IDX_LSB{1'b0}}};

    assign icache.resp_valid      = resp_valid_q;
    assign icache.resp_data       = resp_data_q;
    assign icache.resp_page_fault = resp_fault_q;

    // controller
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= fetch_pkg::IC_IDLE;
            killed_q     <= 1'b0;
            pend_q       <= 1'b0;
            mem_req_q    <= 1'b0;
            resp_valid_q <= 1'b0;
            line_valid_q <= '0;
        end else begin
            // both are single-cycle pulses
            mem_req_q    <= 1'b0;
            resp_valid_q <= 1'b0;
            case (state_q)
                fetch_pkg::IC_IDLE: begin
                    // parked request is either looked up now or killed
                    pend_q <= 1'b0;
                    if (lk_valid && hit) begin
                        resp_valid_q <= 1'b1;
                    end else if (lk_valid) begin
                        state_q   <= fetch_pkg::IC_REFILL;
                        mem_req_q <= 1'b1;
                        killed_q  <= 1'b0;
                    end
                end
                fetch_pkg::IC_REFILL: begin
                    if (icache.kill) begin
                        killed_q <= 1'b1;
                        pend_q   <= 1'b0;
                    end else if (icache.req_valid) begin
                        // new path starts before the old refill returns
                        pend_q <= 1'b1;
                    end
                    if (mem_valid_i) begin
                        line_valid_q[miss_idx] <= 1'b1;
                        // silent return when the lookup was cancelled
                        resp_valid_q <= !(killed_q || icache.kill);
                        state_q      <= fetch_pkg::IC_IDLE;
                    end
                end
                default: begin
                    state_q <= fetch_pkg::IC_IDLE;
                end
            endcase
        end
    end

    // arrays and payload registers
    always_ff @(posedge clk_i) begin
        if (lk_valid) begin
            resp_data_q  <= data_q[lk_idx];
            resp_fault_q <= fault_q[lk_idx];
            miss_addr_q  <= lk_addr;
        end
        if (state_q == fetch_pkg::IC_REFILL && icache.req_valid && !icache.kill) begin
            pend_addr_q <= icache.req_addr;
        end
        if (refill_done) begin
            tag_q[miss_idx]   <= miss_tag;
            data_q[miss_idx]  <= mem_data_i;
            fault_q[miss_idx] <= mem_fault_i;
            // refill word goes straight to the response
            resp_data_q       <= mem_data_i;
            resp_fault_q      <= mem_fault_i;
        end
    end

endmodule

//--- rtl/icache_if.sv
// instruction cache lookup interface with request, kill and response signals and modports
`timescale 1ns/1ps

interface icache_if;

    // one-cycle lookup strobe from stage 1
    logic             req_valid;
    fetch_pkg::xlen_t req_addr;
    // cancels any outstanding lookup, same cycle as a redirect
    logic             kill;

    // response, one cycle after a hit or after the refill data
    logic             resp_valid;
    fetch_pkg::inst_t resp_data;
    logic             resp_page_fault;

    // stage 1 side
    modport fetch_req (
        output req_valid, req_addr, kill
    );

    // cache side
    modport cache (
        input  req_valid, req_addr, kill,
        output resp_valid, resp_data, resp_page_fault
    );

    // stage 2 side
    modport fetch_resp (
        input resp_valid, resp_data, resp_page_fault
    );

endinterface

//--- rtl/if_stage_1.sv
// fetch stage 1 with pc register, next pc and redirect select, misalignment check, cache request
`timescale 1ns/1ps

module if_stage_1 (
    input  logic                clk_i,
    input  logic                rstn_i,
    // decode stall or'ed with the stage 2 miss stall
    input  logic                stall_i,
    input  logic                redirect_valid_i,
    input  fetch_pkg::xlen_t    redirect_pc_i,
    icache_if.fetch_req         icache,
    output fetch_pkg::if1_if2_t fetch_o
);

    fetch_pkg::xlen_t pc_q;
    fetch_pkg::xlen_t pc_d;
    // set one cycle after reset so nothing is issued straight out of reset
    logic             run_q;
    logic             advance;
    logic             misaligned;

    // stage 1 output register
    logic             out_valid_q;
    logic             out_ex_q;
    fetch_pkg::xlen_t out_pc_q;

    // any nonzero low bit means the pc is not word aligned
    assign misaligned = (pc_q[1:0] != 2'b00);

    // move on only when running, not stalled and not redirected
    assign advance = run_q && !stall_i && !redirect_valid_i;

    // lookup for the current pc in the same cycle it is registered
    // misaligned pcs never reach the cache
    assign icache.req_valid = advance && !misaligned;
    assign icache.req_addr  = pc_q;
    // redirect drops whatever the cache is still working on
    assign icache.kill      = redirect_valid_i;

    // next pc select
    always_comb begin
        pc_d = pc_q;
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (advance) begin
            pc_d = pc_q + 32'd4;
        end
    end

    // control state and pc
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q        <= fetch_pkg::RESET_PC;
            run_q       <= 1'b0;
            out_valid_q <= 1'b0;
            out_ex_q    <= 1'b0;
        end else begin
            pc_q  <= pc_d;
            run_q <= 1'b1;
            if (redirect_valid_i) begin
                // item on the old path is dropped
                out_valid_q <= 1'b0;
                out_ex_q    <= 1'b0;
            end else if (advance) begin
                out_valid_q <= 1'b1;
                out_ex_q    <= misaligned;
            end
        end
    end

    // pc of the registered item, payload only
    always_ff @(posedge clk_i) begin
        if (advance) begin
            out_pc_q <= pc_q;
        end
    end

    // pack the output register for stage 2
    always_comb begin
        fetch_o.valid     = out_valid_q;
        fetch_o.pc        = out_pc_q;
        fetch_o.ex.valid  = out_ex_q;
        // only exception stage 1 can raise
        fetch_o.ex.cause  = fetch_pkg::INSTR_ADDR_MISALIGNED;
        // origin is the item pc, stage 2 reuses it for page faults
        fetch_o.ex.origin = out_pc_q;
    end

endmodule

//--- rtl/if_stage_2.sv
// fetch stage 2 with response save register, exception ordering, instruction select, miss stall
`timescale 1ns/1ps

module if_stage_2 (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // item from the stage 1 output register
    input  fetch_pkg::if1_if2_t   fetch_i,
    icache_if.fetch_resp          icache,
    // decode stall
    input  logic                  stall_i,
    // redirect, drops the current item
    input  logic                  flush_i,
    output fetch_pkg::fetch_out_t fetch_o,
    // holds stage 1 while a lookup is outstanding
    output logic                  stall_o
);

    // saved response
    logic             save_valid_q;
    fetch_pkg::inst_t save_data_q;
    logic             save_fault_q;
    logic             save_valid_d;
    logic             capture;

    logic             page_fault;
    logic             have_resp;

    // a page fault from either the saved or the live response
    assign page_fault = (save_valid_q && save_fault_q)
                        || (icache.resp_valid && icache.resp_page_fault);

    // the item can leave once it has a response or an exception
    assign have_resp = icache.resp_valid || save_valid_q || fetch_i.ex.valid;

    // stall stage 1 on a miss
    assign stall_o = fetch_i.valid && !have_resp;

    // output item, stage 1 exception ranks above the page fault
    always_comb begin
        fetch_o.valid = fetch_i.valid && have_resp && !flush_i;
        fetch_o.pc    = fetch_i.pc;
        // saved response wins over the live one
        fetch_o.inst  = save_valid_q ? save_data_q : icache.resp_data;
        if (fetch_i.ex.valid) begin
            fetch_o.ex.valid = 1'b1;
            fetch_o.ex.cause = fetch_i.ex.cause;
        end else if (page_fault) begin
            fetch_o.ex.valid = 1'b1;
            fetch_o.ex.cause = fetch_pkg::INSTR_PAGE_FAULT;
        end else begin
            fetch_o.ex.valid = 1'b0;
            fetch_o.ex.cause = fetch_pkg::INSTR_ADDR_MISALIGNED;
        end
        fetch_o.ex.origin = fetch_i.ex.origin;
    end

    // live response arriving while the decoder is stalled
    assign capture = icache.resp_valid && stall_i;

    // save register valid
    always_comb begin
        if (flush_i) begin
            save_valid_d = 1'b0;
        end else if (capture) begin
            save_valid_d = 1'b1;
        end else if (save_valid_q && !stall_i) begin
            // consumed by the decoder this cycle
            save_valid_d = 1'b0;
        end else begin
            save_valid_d = save_valid_q;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            save_valid_q <= 1'b0;
        end else begin
            save_valid_q <= save_valid_d;
        end
    end

    // saved word and fault flag
    always_ff @(posedge clk_i) begin
        if (capture) begin
            save_data_q  <= icache.resp_data;
            save_fault_q <= icache.resp_page_fault;
        end
    end

endmodule

//--- verif/tb_fetch_top.sv
// testbench for the fetch front end with memory model, stall and redirect stimulus and checker
`timescale 1ns/1ps

module tb_fetch_top;

    // cycles any single wait may take
    localparam int WAIT_LIMIT = 200;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  mem_req_o;
    fetch_pkg::xlen_t      mem_addr_o;
    logic                  mem_valid_i;
    fetch_pkg::inst_t      mem_data_i;
    logic                  mem_fault_i;
    logic                  stall_i;
    logic                  redirect_valid_i;
    fetch_pkg::xlen_t      redirect_pc_i;
    logic                  fetch_valid_o;
    fetch_pkg::xlen_t      fetch_pc_o;
    fetch_pkg::inst_t      fetch_inst_o;
    logic                  fetch_ex_valid_o;
    fetch_pkg::exc_cause_t fetch_ex_cause_o;

    integer           seed;
    // memory model, one refill in flight
    logic             mem_busy;
    int               mem_wait;
    fetch_pkg::xlen_t mem_req_addr;
    // stimulus controls
    logic             stall_random;
    logic             no_mem_req;
    // expected stream
    fetch_pkg::xlen_t exp_pc;
    int               accepted_cnt;
    logic             first_cycle_seen;
    logic             exp_ex;

    fetch_top i_fetch_top (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_valid_i      (mem_valid_i),
        .mem_data_i       (mem_data_i),
        .mem_fault_i      (mem_fault_i),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .fetch_valid_o    (fetch_valid_o),
        .fetch_pc_o       (fetch_pc_o),
        .fetch_inst_o     (fetch_inst_o),
        .fetch_ex_valid_o (fetch_ex_valid_o),
        .fetch_ex_cause_o (fetch_ex_cause_o)
    );

    // instruction word stored at an address
    function automatic fetch_pkg::inst_t ref_word(input fetch_pkg::xlen_t addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    // memory flags a page fault from here upward
    function automatic logic in_fault_region(input fetch_pkg::xlen_t addr);
        return addr >= 32'h0000_2000;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_on_error($sformatf("Mismatch at time %0t: %s", $time, msg));
    endtask

    task automatic check_pc(input fetch_pkg::xlen_t got, input fetch_pkg::xlen_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("pc got %h expected %h", got, exp));
        end
    endtask

    task automatic check_inst(input fetch_pkg::inst_t got, input fetch_pkg::inst_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("inst got %h expected %h at pc %h", got, exp, exp_pc));
        end
    endtask

    task automatic check_cause(input fetch_pkg::exc_cause_t got,
                               input fetch_pkg::exc_cause_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("cause got %0d expected %0d at pc %h", got, exp, exp_pc));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    // 10 ns clock
    always #5 clk_i = ~clk_i;

    // decode stall, high about 30% of the cycles when enabled
    always @(posedge clk_i) begin
        #1;
        if (stall_random) begin
            stall_i = ({$random(seed)} % 10) < 3;
        end else begin
            stall_i = 1'b0;
        end
    end

    // memory request seen, answer after 1 to 6 cycles
    always @(negedge clk_i) begin
        if (rstn_i && mem_req_o) begin
            if (mem_busy) begin
                stop_on_error("a second memory request came while one was still outstanding");
            end else begin
                mem_busy     = 1'b1;
                mem_req_addr = mem_addr_o;
                mem_wait     = {$random(seed)} % 6;
            end
        end
    end

    // single-cycle memory response
    always @(posedge clk_i) begin
        #1;
        mem_valid_i = 1'b0;
        if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_valid_i = 1'b1;
                mem_data_i  = ref_word(mem_req_addr);
                mem_fault_i = in_fault_region(mem_req_addr);
                mem_busy    = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    // checker, sampled mid-cycle when outputs are settled
    always @(negedge clk_i) begin
        // nothing moves in reset and in the cycle right after it
        if (!rstn_i || !first_cycle_seen) begin
            check_flag("fetch_valid_o while quiet", fetch_valid_o, 1'b0);
            check_flag("mem_req_o while quiet", mem_req_o, 1'b0);
        end
        if (rstn_i) begin
            first_cycle_seen = 1'b1;
        end
        // misaligned items must not reach memory
        if (no_mem_req) begin
            check_flag("mem_req_o on a misaligned path", mem_req_o, 1'b0);
        end
        if (redirect_valid_i) begin
            // the flushed item never reaches the decoder
            check_flag("fetch_valid_o during a redirect", fetch_valid_o, 1'b0);
            exp_pc = redirect_pc_i;
        end else if (rstn_i && fetch_valid_o && !stall_i) begin
            // misalignment ranks above a page fault
            exp_ex = (exp_pc[1:0] != 2'b00) || in_fault_region(exp_pc);
            check_pc(fetch_pc_o, exp_pc);
            check_flag("fetch_ex_valid_o", fetch_ex_valid_o, exp_ex);
            if (exp_pc[1:0] != 2'b00) begin
                check_cause(fetch_ex_cause_o, fetch_pkg::INSTR_ADDR_MISALIGNED);
            end else if (exp_ex) begin
                check_cause(fetch_ex_cause_o, fetch_pkg::INSTR_PAGE_FAULT);
            end else begin
                check_inst(fetch_inst_o, ref_word(exp_pc));
            end
            exp_pc       = exp_pc + 32'd4;
            accepted_cnt = accepted_cnt + 1;
        end
    end

    // one more accepted item
    task automatic wait_item();
        int start;
        int cycles;
        start  = accepted_cnt;
        cycles = 0;
        while (accepted_cnt == start) begin
            @(posedge clk_i);
            #1;
            cycles = cycles + 1;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error("no fetch item was accepted within 200 cycles, fetch hangs");
            end
        end
    endtask

    task automatic wait_items(input int count);
        for (int i = 0; i < count; i++) begin
            wait_item();
        end
    endtask

    // returns in the cycle mem_req_o is high
    task automatic wait_refill();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk_i);
            #1;
            cycles = cycles + 1;
            seen   = mem_req_o;
            if (!seen && cycles > WAIT_LIMIT) begin
                stop_on_error("no cache refill started within 200 cycles");
            end
        end
    endtask

    // one-cycle redirect from the current drive point
    task automatic pulse_redirect(input fetch_pkg::xlen_t target);
        redirect_valid_i = 1'b1;
        redirect_pc_i    = target;
        @(posedge clk_i);
        #1;
        redirect_valid_i = 1'b0;
    endtask

    initial begin
        seed             = 32'h2905;
        clk_i            = 1'b0;
        rstn_i           = 1'b0;
        stall_i          = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        mem_valid_i      = 1'b0;
        mem_data_i       = '0;
        mem_fault_i      = 1'b0;
        mem_busy         = 1'b0;
        mem_wait         = 0;
        mem_req_addr     = '0;
        stall_random     = 1'b0;
        no_mem_req       = 1'b0;
        exp_pc           = fetch_pkg::RESET_PC;
        exp_ex           = 1'b0;
        accepted_cnt     = 0;
        first_cycle_seen = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        // straight-line fetch, all misses
        wait_items(40);
        // fill the low lines, then run them again as hits
        pulse_redirect(fetch_pkg::RESET_PC);
        wait_items(12);
        pulse_redirect(fetch_pkg::RESET_PC);
        wait_items(12);
        // same stream under random decode stall
        stall_random = 1'b1;
        pulse_redirect(fetch_pkg::RESET_PC);
        wait_items(40);
        // redirect while a refill is in flight
        wait_refill();
        pulse_redirect(32'h0000_0800);
        wait_items(8);
        // into the fault region
        pulse_redirect(32'h0000_2000);
        wait_items(6);
        // misaligned target, checked for memory silence
        pulse_redirect(32'h0000_0302);
        no_mem_req = 1'b1;
        wait_items(2);
        no_mem_req = 1'b0;
        // back on an aligned path
        pulse_redirect(32'h0000_0400);
        wait_items(10);
        $display("=== PASS ===");
        $finish;
    end

endmodule
